//--- compile.f
+incdir+.
timer_pkg.sv
timer_apb_decode.sv
timer_timebase.sv
timer_compare_channel.sv
timer_readback.sv
timer_subsys.sv
timer_checker.sv
tb_timer_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module tb_timer_subsys -f compile.f \
	&& ./obj_dir/Vtb_timer_subsys | tee sim.log \
	|| echo "build or simulation did not complete"
grep -q "ALL TESTS PASSED" sim.log && echo "run.sh: pass" \
	|| { echo "run.sh: fail"; exit 1; }

//--- tb_timer_subsys.sv
`timescale 1ns/1ns
`default_nettype none

`include "timer_settings.svh"

module tb_timer_subsys;

	localparam int AW = `TIMER_APB_ADDR_W;
	localparam int DW = `TIMER_DATA_W;
	localparam int N  = `TIMER_N_CHANNELS;

	localparam int N_RANDOM     = 400;
	localparam int N_DIRECTED   = 160;
	localparam int HALT_CYCLES  = 8 * (48 + 32);
	localparam int COUNT_CYCLES = 16 * 32 + N * 80;
	localparam int TIMEOUT_CYCLES = (N_RANDOM + N_DIRECTED) * 8 + HALT_CYCLES
		+ COUNT_CYCLES + 64;

	logic			clk;
	logic			rst_n;
	logic			psel;
	logic			penable;
	logic			pwrite;
	logic [AW-1:0]		paddr;
	logic [DW-1:0]		pwdata;
	logic			dbg_halt;
	wire [DW-1:0]		prdata;
	wire			pready;
	wire			pslverr;
	wire [N-1:0]		irq;
	int			error_count;
	int			check_count;
	logic [31:0]		lcg_state = 32'd83996;

	timer_subsys u_dut (
		.clk		(clk),
		.rst_n		(rst_n),
		.psel		(psel),
		.penable	(penable),
		.pwrite		(pwrite),
		.paddr		(paddr),
		.pwdata		(pwdata),
		.dbg_halt	(dbg_halt),
		.prdata		(prdata),
		.pready		(pready),
		.pslverr	(pslverr),
		.irq		(irq)
	);

	timer_checker u_checker (
		.clk		(clk),
		.rst_n		(rst_n),
		.psel		(psel),
		.penable	(penable),
		.pwrite		(pwrite),
		.paddr		(paddr),
		.pwdata		(pwdata),
		.dbg_halt	(dbg_halt),
		.prdata		(prdata),
		.pready		(pready),
		.pslverr	(pslverr),
		.irq		(irq),
		.error_count	(error_count),
		.check_count	(check_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Random numbers and bus helpers
	// ------------------------------------------------------------------

	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Low LCG bits are weak, so draw from the upper ones
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = rand32();
		return int'((r >> 8) % 32'(n));
	endfunction

	function automatic int cmp_ofs(input int k, input logic hi);
		return `TIMER_OFS_CMP_BASE + 8 * k + (hi ? 4 : 0);
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic idle_gap();
		wait_cycles(rand_below(4));
	endtask

	// Starts right after a rising edge, ends on the edge that completes it
	task automatic apb_xfer(input logic wr, input int ofs, input logic [DW-1:0] wdata,
			output logic [DW-1:0] rdata);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= AW'(ofs);
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);
		rdata = prdata;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic reg_write(input int ofs, input logic [DW-1:0] data);
		logic [DW-1:0] rd;
		apb_xfer(1'b1, ofs, data, rd);
		idle_gap();
	endtask

	task automatic reg_read(input int ofs, output logic [DW-1:0] data);
		apb_xfer(1'b0, ofs, rand32(), data);
		idle_gap();
	endtask

	// ------------------------------------------------------------------
	// Test phases
	// ------------------------------------------------------------------

	task automatic read_all_registers();
		logic [DW-1:0] rd;
		reg_read(`TIMER_OFS_CTRL, rd);
		reg_read(`TIMER_OFS_IRQ, rd);
		reg_read(`TIMER_OFS_MTIME_LO, rd);
		reg_read(`TIMER_OFS_MTIME_HI, rd);
		for (int k = 0; k < N; k++) begin
			reg_read(cmp_ofs(k, 1'b0), rd);
			reg_read(cmp_ofs(k, 1'b1), rd);
		end
	endtask

	task automatic run_counting();
		logic [DW-1:0] rd;
		reg_write(`TIMER_OFS_CTRL, 32'd1);
		for (int i = 0; i < 16; i++) begin
			wait_cycles(rand_below(32));
			reg_read(`TIMER_OFS_MTIME_LO, rd);
			reg_read(`TIMER_OFS_MTIME_HI, rd);
		end
		// Five cycles per pass walks the write edge through every
		// prescaler phase, first for the low half and then the high half
		for (int i = 0; i < 2 * `TIMER_CLK_MHZ; i++) begin
			apb_xfer(1'b1, (i < `TIMER_CLK_MHZ) ? `TIMER_OFS_MTIME_LO : `TIMER_OFS_MTIME_HI,
				rand32(), rd);
			apb_xfer(1'b0, `TIMER_OFS_MTIME_LO, rand32(), rd);
			wait_cycles(1);
		end
	endtask

	task automatic run_halt();
		logic [DW-1:0] rd;
		for (int i = 0; i < 8; i++) begin
			dbg_halt <= 1'b1;
			wait_cycles(1 + rand_below(48));
			reg_read(`TIMER_OFS_MTIME_LO, rd);
			dbg_halt <= 1'b0;
			wait_cycles(rand_below(32));
			reg_read(`TIMER_OFS_MTIME_LO, rd);
		end
	endtask

	task automatic run_compare();
		logic [DW-1:0] now;
		logic [DW-1:0] rd;
		reg_write(`TIMER_OFS_MTIME_HI, '0);
		reg_write(`TIMER_OFS_MTIME_LO, 32'h0000_1000);
		for (int k = 0; k < N; k++) begin
			reg_read(`TIMER_OFS_MTIME_LO, now);
			reg_write(cmp_ofs(k, 1'b1), '0);
			reg_write(cmp_ofs(k, 1'b0), now + DW'(2 + rand_below(3)));
			wait_cycles(64);
			reg_read(`TIMER_OFS_IRQ, rd);
			// Deadline moved far out, so the interrupt drops
			reg_write(cmp_ofs(k, 1'b0), now + 32'd4096);
			wait_cycles(2);
			reg_read(`TIMER_OFS_IRQ, rd);
		end
	endtask

	task automatic run_random_sweep();
		int ofs;
		logic wr;
		logic [DW-1:0] rd;
		for (int i = 0; i < N_RANDOM; i++) begin
			if (rand_below(8) == 0)
				dbg_halt <= ~dbg_halt;
			// Mostly the low map with its holes, sometimes anywhere
			if (rand_below(16) < 14)
				ofs = 4 * rand_below(16);
			else
				ofs = 4 * rand_below(1 << (AW - 2));
			wr = (rand_below(2) == 1);
			apb_xfer(wr, ofs, rand32(), rd);
			idle_gap();
		end
		dbg_halt <= 1'b0;
	endtask

	initial begin
		rst_n <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		dbg_halt <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		read_all_registers();
		run_counting();
		run_halt();
		run_compare();
		run_random_sweep();
		read_all_registers();
		wait_cycles(4);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		wait_cycles(TIMEOUT_CYCLES);
		$display("timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- timer_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "timer_settings.svh"

module timer_checker (
	input  wire				clk,
	input  wire				rst_n,
	input  wire				psel,
	input  wire				penable,
	input  wire				pwrite,
	input  wire [`TIMER_APB_ADDR_W-1:0]	paddr,
	input  wire [`TIMER_DATA_W-1:0]		pwdata,
	input  wire				dbg_halt,
	input  wire [`TIMER_DATA_W-1:0]		prdata,
	input  wire				pready,
	input  wire				pslverr,
	input  wire [`TIMER_N_CHANNELS-1:0]	irq,
	output int				error_count,
	output int				check_count
);

	import timer_pkg::*;

	localparam int N  = `TIMER_N_CHANNELS;
	localparam int DW = `TIMER_DATA_W;

	// Reference model state
	logic		m_en;
	int		m_pre;
	timer_word_t	m_mtime;
	timer_word_t	m_cmp [N];
	logic [N-1:0]	m_irq;

	logic		acc;
	logic		exp_err;
	logic		wr_ok;
	logic		tick;
	int		idx;

	// Register number of a byte offset in the order ctrl, irq, mtime lo/hi
	// and then the cmp pairs
	// -1 means nothing is mapped there
	function automatic int map_offset(input int ofs);
		int r;
		r = -1;
		case (ofs)
			`TIMER_OFS_CTRL:     r = 0;
			`TIMER_OFS_IRQ:      r = 1;
			`TIMER_OFS_MTIME_LO: r = 2;
			`TIMER_OFS_MTIME_HI: r = 3;
			default: begin
				for (int k = 0; k < N; k++) begin
					if (ofs == `TIMER_OFS_CMP_BASE + 8 * k)
						r = 4 + 2 * k;
					if (ofs == `TIMER_OFS_CMP_BASE + 8 * k + 4)
						r = 5 + 2 * k;
				end
			end
		endcase
		return r;
	endfunction

	function automatic logic [DW-1:0] model_read(input int r);
		logic [DW-1:0] v;
		v = '0;
		case (r)
			0: v[0] = m_en;
			1: v[N-1:0] = m_irq;
			2: v = m_mtime.half.lo;
			3: v = m_mtime.half.hi;
			default: begin
				if (r >= 4 && r % 2 == 1)
					v = m_cmp[(r - 4) / 2].half.hi;
				else if (r >= 4)
					v = m_cmp[(r - 4) / 2].half.lo;
			end
		endcase
		return v;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	// ------------------------------------------------------------------
	// Compare before the edge, then step the model across it
	// ------------------------------------------------------------------

	always @(posedge clk) begin
		if (!rst_n) begin
			m_en = 1'b0;
			m_pre = 0;
			m_mtime.count = '0;
			for (int k = 0; k < N; k++)
				m_cmp[k].count = '1;
			m_irq = '0;
		end else begin
			acc = psel && penable;
			idx = map_offset(int'(paddr));
			exp_err = acc && (idx < 0 || (pwrite && idx == 1));
			wr_ok = acc && pwrite && !exp_err;

			compare_value("irq", 64'(m_irq), 64'(irq));
			compare_value("pslverr", 64'(exp_err), 64'(pslverr));
			if (acc)
				compare_value("pready", 64'(1'b1), 64'(pready));
			if (acc && !pwrite)
				compare_value("prdata", 64'(model_read(idx)), 64'(prdata));

			tick = m_en && !dbg_halt && (m_pre == `TIMER_CLK_MHZ - 1);
			for (int k = 0; k < N; k++)
				m_irq[k] = (m_mtime.count >= m_cmp[k].count);
			if (m_en && !dbg_halt)
				m_pre = tick ? 0 : m_pre + 1;

			// A bus write to mtime beats the tick
			if (tick && !(wr_ok && (idx == 2 || idx == 3)))
				m_mtime.count = m_mtime.count + 64'd1;
			if (wr_ok) begin
				case (idx)
					0: m_en = pwdata[0];
					2: m_mtime.half.lo = pwdata;
					3: m_mtime.half.hi = pwdata;
					default: begin
						if (idx % 2 == 1)
							m_cmp[(idx - 4) / 2].half.hi = pwdata;
						else
							m_cmp[(idx - 4) / 2].half.lo = pwdata;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- timer_subsys.sv
`timescale 1ns/1ns
`default_nettype none

`include "timer_settings.svh"

module timer_subsys (
	input  wire				clk,
	input  wire				rst_n,
	input  wire				psel,
	input  wire				penable,
	input  wire				pwrite,
	input  wire [`TIMER_APB_ADDR_W-1:0]	paddr,
	input  wire [`TIMER_DATA_W-1:0]		pwdata,
	input  wire				dbg_halt,
	output logic [`TIMER_DATA_W-1:0]	prdata,
	output logic				pready,
	output logic				pslverr,
	output logic [`TIMER_N_CHANNELS-1:0]	irq
);

	import timer_pkg::*;

	logic				ctrl_we;
	logic				mtime_lo_we;
	logic				mtime_hi_we;
	logic [`TIMER_N_CHANNELS-1:0]	cmp_lo_we;
	logic [`TIMER_N_CHANNELS-1:0]	cmp_hi_we;
	logic [`TIMER_SEL_W-1:0]	rd_sel;
	logic				ctrl_en;
	timer_word_t			mtime;
	timer_word_t			cmp [`TIMER_N_CHANNELS];

	// No wait states anywhere in the register block
	assign pready = 1'b1;

	// ------------------------------------------------------------------
	// Bus decode and timebase
	// ------------------------------------------------------------------

	timer_apb_decode u_decode (
		.psel		(psel),
		.penable	(penable),
		.pwrite		(pwrite),
		.paddr		(paddr),
		.ctrl_we	(ctrl_we),
		.mtime_lo_we	(mtime_lo_we),
		.mtime_hi_we	(mtime_hi_we),
		.cmp_lo_we	(cmp_lo_we),
		.cmp_hi_we	(cmp_hi_we),
		.rd_sel		(rd_sel),
		.pslverr	(pslverr)
	);

	timer_timebase u_timebase (
		.clk		(clk),
		.rst_n		(rst_n),
		.dbg_halt	(dbg_halt),
		.ctrl_we	(ctrl_we),
		.mtime_lo_we	(mtime_lo_we),
		.mtime_hi_we	(mtime_hi_we),
		.pwdata		(pwdata),
		.ctrl_en	(ctrl_en),
		.mtime		(mtime)
	);

	// ------------------------------------------------------------------
	// Compare channels and readback
	// ------------------------------------------------------------------

	for (genvar k = 0; k < `TIMER_N_CHANNELS; k++) begin : g_chan
		timer_compare_channel u_chan (
			.clk		(clk),
			.rst_n		(rst_n),
			.cmp_lo_we	(cmp_lo_we[k]),
			.cmp_hi_we	(cmp_hi_we[k]),
			.pwdata		(pwdata),
			.mtime		(mtime),
			.cmp		(cmp[k]),
			.irq		(irq[k])
		);
	end

	timer_readback u_readback (
		.rd_sel		(rd_sel),
		.ctrl_en	(ctrl_en),
		.mtime		(mtime),
		.cmp		(cmp),
		.irq		(irq),
		.prdata		(prdata)
	);

endmodule

`default_nettype wire

//--- timer_readback.sv
`timescale 1ns/1ns
`default_nettype none

`include "timer_settings.svh"

module timer_readback (
	input  wire [`TIMER_SEL_W-1:0]		rd_sel,
	input  wire				ctrl_en,
	input  timer_pkg::timer_word_t		mtime,
	input  timer_pkg::timer_word_t		cmp [`TIMER_N_CHANNELS],
	input  wire [`TIMER_N_CHANNELS-1:0]	irq,
	output logic [`TIMER_DATA_W-1:0]	prdata
);

	import timer_pkg::*;

	localparam int unsigned SW = `TIMER_SEL_W;
	localparam int unsigned DW = `TIMER_DATA_W;

	timer_word_t		cmp_sel;
	logic			cmp_hit;
	logic [DW-1:0]		status;

	// Pending bits in the low positions, the rest read as zero
	assign status = DW'(irq);

	// ------------------------------------------------------------------
	// Compare channel select
	// ------------------------------------------------------------------

	// Each channel owns an even/odd index pair, so dropping bit 0 names
	// the channel and bit 0 picks the half
	always_comb begin
		cmp_sel = '0;
		cmp_hit = 1'b0;
		for (int k = 0; k < `TIMER_N_CHANNELS; k++) begin
			if ((rd_sel >> 1) == SW'(`TIMER_SEL_CMP_BASE / 2 + k)) begin
				cmp_sel = cmp[k];
				cmp_hit = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// Read data mux
	// ------------------------------------------------------------------

	always_comb begin
		case (rd_sel)
			SW'(`TIMER_SEL_CTRL):     prdata = {{(DW-1){1'b0}}, ctrl_en};
			SW'(`TIMER_SEL_IRQ):      prdata = status;
			SW'(`TIMER_SEL_MTIME_LO): prdata = mtime.half.lo;
			SW'(`TIMER_SEL_MTIME_HI): prdata = mtime.half.hi;
			default: begin
				if (cmp_hit)
					prdata = rd_sel[0] ? cmp_sel.half.hi : cmp_sel.half.lo;
				else
					prdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- timer_compare_channel.sv
`timescale 1ns/1ns
`default_nettype none

`include "timer_settings.svh"

module timer_compare_channel (
	input  wire				clk,
	input  wire				rst_n,
	input  wire				cmp_lo_we,
	input  wire				cmp_hi_we,
	input  wire [`TIMER_DATA_W-1:0]		pwdata,
	input  timer_pkg::timer_word_t		mtime,
	output timer_pkg::timer_word_t		cmp,
	output logic				irq
);

	// ------------------------------------------------------------------
	// mtimecmp register
	// ------------------------------------------------------------------

	// All ones out of reset keeps the interrupt quiet until software
	// programs a real deadline
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmp.count <= '1;
		end else if (cmp_lo_we) begin
			cmp.half.lo <= pwdata;
		end else if (cmp_hi_we) begin
			cmp.half.hi <= pwdata;
		end
	end

	// ------------------------------------------------------------------
	// Interrupt
	// ------------------------------------------------------------------

	// Level interrupt, one cycle behind the comparison
	// Software clears it by moving cmp above mtime
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq <= 1'b0;
		end else begin
			irq <= (mtime.count >= cmp.count);
		end
	end

endmodule

`default_nettype wire

//--- timer_timebase.sv
`timescale 1ns/1ns
`default_nettype none

`include "timer_settings.svh"

module timer_timebase (
	input  wire				clk,
	input  wire				rst_n,
	input  wire				dbg_halt,
	input  wire				ctrl_we,
	input  wire				mtime_lo_we,
	input  wire				mtime_hi_we,
	input  wire [`TIMER_DATA_W-1:0]		pwdata,
	output logic				ctrl_en,
	output timer_pkg::timer_word_t		mtime
);

	// Wide enough for CLK_MHZ-1, and never zero bits wide
	localparam int unsigned PW = $clog2(`TIMER_CLK_MHZ + 1);

	logic [PW-1:0]	prescale;
	logic		run;
	logic		tick;

	// ------------------------------------------------------------------
	// Enable register
	// ------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b0;
		end else if (ctrl_we) begin
			ctrl_en <= pwdata[0];
		end
	end

	// ------------------------------------------------------------------
	// Microsecond prescaler
	// ------------------------------------------------------------------

	// Time stands still while the hart is halted by the debugger
	assign run  = ctrl_en && !dbg_halt;
	assign tick = run && (prescale == PW'(`TIMER_CLK_MHZ - 1));

	// Enable writes leave the phase alone, so counting resumes where it stopped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prescale <= '0;
		end else if (run) begin
			if (tick)
				prescale <= '0;
			else
				prescale <= prescale + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// mtime
	// ------------------------------------------------------------------

	// A bus write to either half takes priority and swallows a same-cycle tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime.count <= '0;
		end else if (mtime_lo_we) begin
			mtime.half.lo <= pwdata;
		end else if (mtime_hi_we) begin
			mtime.half.hi <= pwdata;
		end else if (tick) begin
			mtime.count <= mtime.count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- timer_apb_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "timer_settings.svh"

module timer_apb_decode (
	input  wire				psel,
	input  wire				penable,
	input  wire				pwrite,
	input  wire [`TIMER_APB_ADDR_W-1:0]	paddr,
	output logic				ctrl_we,
	output logic				mtime_lo_we,
	output logic				mtime_hi_we,
	output logic [`TIMER_N_CHANNELS-1:0]	cmp_lo_we,
	output logic [`TIMER_N_CHANNELS-1:0]	cmp_hi_we,
	output logic [`TIMER_SEL_W-1:0]		rd_sel,
	output logic				pslverr
);

	localparam int unsigned AW = `TIMER_APB_ADDR_W;
	localparam int unsigned SW = `TIMER_SEL_W;

	logic access;
	logic wr_access;
	logic unmapped;

	// Access cycle of a transfer; pready is always high so it completes here
	assign access    = psel && penable;
	assign wr_access = access && pwrite;

	// ------------------------------------------------------------------
	// Address to register index
	// ------------------------------------------------------------------

	always_comb begin
		rd_sel = SW'(`TIMER_SEL_NONE);
		if (paddr == AW'(`TIMER_OFS_CTRL))
			rd_sel = SW'(`TIMER_SEL_CTRL);
		if (paddr == AW'(`TIMER_OFS_IRQ))
			rd_sel = SW'(`TIMER_SEL_IRQ);
		if (paddr == AW'(`TIMER_OFS_MTIME_LO))
			rd_sel = SW'(`TIMER_SEL_MTIME_LO);
		if (paddr == AW'(`TIMER_OFS_MTIME_HI))
			rd_sel = SW'(`TIMER_SEL_MTIME_HI);
		for (int k = 0; k < `TIMER_N_CHANNELS; k++) begin
			if (paddr == AW'(`TIMER_OFS_CMP_BASE + 8 * k))
				rd_sel = SW'(`TIMER_SEL_CMP_BASE + 2 * k);
			if (paddr == AW'(`TIMER_OFS_CMP_BASE + 8 * k + 4))
				rd_sel = SW'(`TIMER_SEL_CMP_BASE + 2 * k + 1);
		end
	end

	assign unmapped = (rd_sel == SW'(`TIMER_SEL_NONE));

	// Status register is read-only, so a write to it is an error too
	assign pslverr = access && (unmapped || (pwrite && rd_sel == SW'(`TIMER_SEL_IRQ)));

	// ------------------------------------------------------------------
	// Write strobes, at most one per access cycle
	// ------------------------------------------------------------------

	assign ctrl_we     = wr_access && (rd_sel == SW'(`TIMER_SEL_CTRL));
	assign mtime_lo_we = wr_access && (rd_sel == SW'(`TIMER_SEL_MTIME_LO));
	assign mtime_hi_we = wr_access && (rd_sel == SW'(`TIMER_SEL_MTIME_HI));

	always_comb begin
		for (int k = 0; k < `TIMER_N_CHANNELS; k++) begin
			cmp_lo_we[k] = wr_access && (rd_sel == SW'(`TIMER_SEL_CMP_BASE + 2 * k));
			cmp_hi_we[k] = wr_access && (rd_sel == SW'(`TIMER_SEL_CMP_BASE + 2 * k + 1));
		end
	end

endmodule

`default_nettype wire

//--- timer_pkg.sv
`default_nettype none

`include "timer_settings.svh"

package timer_pkg;

	// One 64-bit timer word, seen as a count or as two bus-sized halves
	typedef struct packed {
		logic [`TIMER_DATA_W-1:0] hi;
		logic [`TIMER_DATA_W-1:0] lo;
	} timer_halves_t;

	typedef union packed {
		logic [2*`TIMER_DATA_W-1:0] count;
		timer_halves_t half;
	} timer_word_t;

endpackage

`default_nettype wire

//--- timer_settings.svh
`ifndef TIMER_SETTINGS_SVH
`define TIMER_SETTINGS_SVH

// Subsystem size and timebase
`define TIMER_N_CHANNELS	4
`define TIMER_CLK_MHZ		12

// Bus widths
`define TIMER_APB_ADDR_W	16
`define TIMER_DATA_W		32

// Register map as byte offsets
`define TIMER_OFS_CTRL		'h00
`define TIMER_OFS_IRQ		'h04
`define TIMER_OFS_MTIME_LO	'h08
`define TIMER_OFS_MTIME_HI	'h0C
`define TIMER_OFS_CMP_BASE	'h10

// Decoded register index; cmp lo/hi pairs start at an even index
`define TIMER_SEL_CTRL		0
`define TIMER_SEL_IRQ		1
`define TIMER_SEL_MTIME_LO	2
`define TIMER_SEL_MTIME_HI	3
`define TIMER_SEL_CMP_BASE	4
`define TIMER_SEL_NONE		(`TIMER_SEL_CMP_BASE + 2 * `TIMER_N_CHANNELS)
`define TIMER_SEL_W		$clog2(`TIMER_SEL_NONE + 1)

`endif
